// ==== Makefile ====
SIM      = verilator
TOP      = tb_dcache_pair
FILELIST = src.f
FLAGS    = --binary --timing -Wno-fatal -j 0
MDIR     = obj_dir

BIN  = $(MDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(MDIR)/V%: $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(MDIR) -o V$*

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(MDIR)

// ==== bench/tb_dcache_pair.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache_pair import cache_geom_pkg::*, load_req_pkg::*; ();

    // tests run for roughly 500 cycles
    localparam int MAX_CYCLES    = 2000;
    localparam int STREAM_FILLS  = 24;
    localparam int STREAM_LOADS  = 120;

    logic     clk;
    logic     rst_n_i;
    logic     req_valid_i;
    addr_t    req_addr_i;
    size_e    req_size_i;
    logic     req_sext_i;
    ooo_tag_t req_tag_i;
    logic     fill_valid_i;
    addr_t    fill_addr_i;
    line_t    fill_line_i;
    logic     load_valid_o;
    logic     load_hit_o;
    word_t    load_data_o;
    ooo_tag_t load_tag_o;

    // cache model with one slot per bank and set
    logic        slot_present [32];
    logic [27:0] slot_line    [32];
    line_t       slot_data    [32];

    int err_count;
    int check_count;
    int test_err_base;
    int cycles;

    dcache_pair u_dcache_pair (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_size_i   (req_size_i),
        .req_sext_i   (req_sext_i),
        .req_tag_i    (req_tag_i),
        .fill_valid_i (fill_valid_i),
        .fill_addr_i  (fill_addr_i),
        .fill_line_i  (fill_line_i),
        .load_valid_o (load_valid_o),
        .load_hit_o   (load_hit_o),
        .load_data_o  (load_data_o),
        .load_tag_o   (load_tag_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;   // inputs change just after the edge
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    function automatic line_t random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // built byte by byte from the model and then extended
    function automatic void expect_load(input addr_t addr, input size_e size, input logic sext,
                                        output logic hit, output word_t data);
        int         nbytes;
        addr_t      a;
        logic [4:0] slot;
        logic       msb;
        nbytes = 1 << int'(size);
        hit    = 1'b1;
        data   = '0;
        for (int i = 0; i < nbytes; i++) begin
            a    = addr + addr_t'(i);
            slot = a[8:4];
            if (!slot_present[slot] || slot_line[slot] != a[31:4]) begin
                hit = 1'b0;
            end
            data[i*8 +: 8] = slot_data[slot][a[3:0]*8 +: 8];
        end
        msb = data[nbytes*8-1];
        for (int j = nbytes * 8; j < 32; j++) begin
            data[j] = sext & msb;
        end
    endfunction

    task automatic fill_line(input addr_t addr, input line_t data);
        slot_present[addr[8:4]] = 1'b1;   // evicts whatever shared the slot
        slot_line[addr[8:4]]    = addr[31:4];
        slot_data[addr[8:4]]    = data;
        fill_valid_i = 1'b1;
        fill_addr_i  = addr;
        fill_line_i  = data;
        next_cycle();
        fill_valid_i = 1'b0;
    endtask

    // single load whose result pulse lasts one cycle
    task automatic do_load(input addr_t addr, input size_e size, input logic sext);
        logic     exp_hit;
        word_t    exp_data;
        ooo_tag_t tag;
        tag = ooo_tag_t'($urandom_range(0, 1023));
        expect_load(addr, size, sext, exp_hit, exp_data);
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        req_size_i  = size;
        req_sext_i  = sext;
        req_tag_i   = tag;
        next_cycle();
        req_valid_i = 1'b0;
        check_eq("load_valid_o", 32'(load_valid_o), 32'd1);
        check_eq("load_hit_o", 32'(load_hit_o), 32'(exp_hit));
        if (exp_hit) begin
            check_eq("load_data_o", load_data_o, exp_data);
        end
        check_eq("load_tag_o", 32'(load_tag_o), 32'(tag));
        next_cycle();
        check_eq("load_valid_o", 32'(load_valid_o), 32'd0);
    endtask

    task automatic reset_miss_loads();
        do_load(32'h0000_0000, SIZE_WORD, 1'b0);
        do_load(32'h0000_1234, SIZE_BYTE, 1'b1);
        do_load(32'h0000_201e, SIZE_HALF, 1'b0);
        do_load(32'h8000_001f, SIZE_WORD, 1'b1);   // crossing load is still a miss
        do_load(32'hffff_ff00, SIZE_WORD, 1'b0);
        end_test("reset_miss");
    endtask

    task automatic aligned_loads();
        line_t data;
        addr_t base;
        for (int ln = 0; ln < 4; ln++) begin
            data = random_line();
            if (ln % 2 == 0) begin
                data = data | {4{32'h8000_8080}};   // top bits set for sign checks
            end
            fill_line(32'h0000_1000 + addr_t'(ln * 16), data);
        end
        for (int ln = 0; ln < 4; ln++) begin
            for (int k = 0; k < 4; k++) begin
                base = 32'h0000_1000 + addr_t'(ln * 16 + k * 4);
                for (int s = 0; s < 2; s++) begin
                    do_load(base, SIZE_WORD, 1'(s));
                    do_load(base + 2, SIZE_HALF, 1'(s));
                    do_load(base, SIZE_BYTE, 1'(s));
                    do_load(base + 2, SIZE_BYTE, 1'(s));
                end
            end
        end
        end_test("aligned");
    endtask

    task automatic crossing_loads();
        fill_line(32'h0000_2000, random_line() | {8{16'h8000}});
        fill_line(32'h0000_2010, random_line());
        fill_line(32'h0000_2020, random_line() | {8{16'h0080}});
        do_load(32'h0000_200d, SIZE_WORD, 1'b0);   // even into odd
        do_load(32'h0000_200e, SIZE_WORD, 1'b1);
        do_load(32'h0000_200f, SIZE_WORD, 1'b1);
        do_load(32'h0000_200f, SIZE_HALF, 1'b1);
        do_load(32'h0000_201d, SIZE_WORD, 1'b0);   // odd into next even
        do_load(32'h0000_201f, SIZE_WORD, 1'b1);
        do_load(32'h0000_201f, SIZE_HALF, 1'b0);
        // set 15 of the odd bank wraps to set 0 of the even bank
        fill_line(32'h0000_31f0, random_line() | {16{8'h80}});
        fill_line(32'h0000_3200, random_line() | {16{8'h80}});
        do_load(32'h0000_31fd, SIZE_WORD, 1'b0);
        do_load(32'h0000_31fe, SIZE_WORD, 1'b1);
        do_load(32'h0000_31ff, SIZE_HALF, 1'b1);
        end_test("crossing");
    endtask

    task automatic half_filled_loads();
        fill_line(32'h0000_0a40, random_line());
        do_load(32'h0000_0a4e, SIZE_WORD, 1'b0);   // second line missing
        do_load(32'h0000_0a4f, SIZE_HALF, 1'b1);
        fill_line(32'h0000_0a50, random_line());
        do_load(32'h0000_0a4e, SIZE_WORD, 1'b0);
        do_load(32'h0000_0a4f, SIZE_HALF, 1'b1);
        end_test("half_filled");
    endtask

    task automatic tag_conflict_loads();
        fill_line(32'h0000_0c80, random_line());
        do_load(32'h0000_0c84, SIZE_WORD, 1'b0);
        fill_line(32'h0000_0e80, random_line());   // same slot with the tag plus one
        do_load(32'h0000_0c84, SIZE_WORD, 1'b0);
        do_load(32'h0000_0e84, SIZE_WORD, 1'b0);
        do_load(32'h0000_0e8b, SIZE_BYTE, 1'b1);
        end_test("tag_conflict");
    endtask

    task automatic random_load_stream();
        addr_t    addr;
        size_e    size;
        logic     sext;
        ooo_tag_t tag;
        logic     exp_hit;
        word_t    exp_data;
        logic     q_hit  [$];
        word_t    q_data [$];
        ooo_tag_t q_tag  [$];
        logic     h;
        word_t    d;
        ooo_tag_t t;
        for (int i = 0; i < STREAM_FILLS; i++) begin
            fill_line(32'h0000_4000 + addr_t'($urandom_range(0, 63) * 16), random_line());
        end
        for (int i = 0; i <= STREAM_LOADS; i++) begin
            if (i > 0) begin
                h = q_hit.pop_front();
                d = q_data.pop_front();
                t = q_tag.pop_front();
                check_eq("load_valid_o", 32'(load_valid_o), 32'd1);
                check_eq("load_hit_o", 32'(load_hit_o), 32'(h));
                if (h) begin
                    check_eq("load_data_o", load_data_o, d);
                end
                check_eq("load_tag_o", 32'(load_tag_o), 32'(t));
            end
            if (i < STREAM_LOADS) begin
                addr = 32'h0000_4000 + addr_t'($urandom_range(0, 1023));
                size = size_e'($urandom_range(0, 2));
                sext = 1'($urandom_range(0, 1));
                tag  = ooo_tag_t'($urandom_range(0, 1023));
                expect_load(addr, size, sext, exp_hit, exp_data);
                q_hit.push_back(exp_hit);
                q_data.push_back(exp_data);
                q_tag.push_back(tag);
                req_valid_i = 1'b1;
                req_addr_i  = addr;
                req_size_i  = size;
                req_sext_i  = sext;
                req_tag_i   = tag;
            end else begin
                req_valid_i = 1'b0;
            end
            next_cycle();
        end
        check_eq("load_valid_o", 32'(load_valid_o), 32'd0);
        end_test("random_stream");
    endtask

    initial begin
        void'($urandom(32'h752d));
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        req_valid_i   = 1'b0;
        req_addr_i    = '0;
        req_size_i    = SIZE_BYTE;
        req_sext_i    = 1'b0;
        req_tag_i     = '0;
        fill_valid_i  = 1'b0;
        fill_addr_i   = '0;
        fill_line_i   = '0;
        err_count     = 0;
        check_count   = 0;
        test_err_base = 0;
        cycles        = 0;
        for (int i = 0; i < 32; i++) begin
            slot_present[i] = 1'b0;
            slot_line[i]    = '0;
            slot_data[i]    = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        next_cycle();
        reset_miss_loads();
        aligned_loads();
        crossing_loads();
        half_filled_loads();
        tag_conflict_loads();
        random_load_stream();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/bank_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface bank_if import cache_geom_pkg::*; ();

    // lookup of one candidate line
    logic   lookup_valid;
    index_t lookup_index;
    ctag_t  lookup_tag;

    // whole-line fill
    logic   fill_valid;
    index_t fill_index;
    ctag_t  fill_tag;
    line_t  fill_line;

    logic   rd_hit;    // one clock after lookup_valid
    line_t  rd_line;

    modport split (
        output lookup_valid, lookup_index, lookup_tag,
        output fill_valid, fill_index, fill_tag, fill_line
    );

    modport bank (
        input  lookup_valid, lookup_index, lookup_tag,
        input  fill_valid, fill_index, fill_tag, fill_line,
        output rd_hit, rd_line
    );

    modport merge (
        input  rd_hit, rd_line
    );

endinterface

`default_nettype wire

// ==== hdl/bank_req_split.sv ====
`timescale 1ns/1ns
`default_nettype none

module bank_req_split import cache_geom_pkg::*; (
    input  logic  req_valid_i,
    input  addr_t req_addr_i,
    input  logic  fill_valid_i,
    input  addr_t fill_addr_i,
    input  line_t fill_line_i,
    bank_if.split bank_o [NUM_BANKS]
);

    logic [LINE_NUM_W-1:0] line_a;   // addressed line
    logic [LINE_NUM_W-1:0] line_b;   // line after it
    logic                  fill_bank;
    index_t                fill_index;
    ctag_t                 fill_tag;

    // the next line may wrap from set 15 of the odd bank
    // into set 0 of the even bank, the carry moves into the tag
    assign line_a = req_addr_i[ADDR_W-1:OFFSET_W];
    assign line_b = line_a + 1'b1;

    // fill address decode
    assign fill_bank  = fill_addr_i[OFFSET_W];
    assign fill_index = fill_addr_i[OFFSET_W+BANK_W +: INDEX_W];
    assign fill_tag   = fill_addr_i[ADDR_W-1 -: TAG_W];

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_route
        localparam logic PARITY = 1'(b);

        logic [LINE_NUM_W-1:0] lnum;

        // each bank gets whichever candidate has its parity
        assign lnum = (line_a[0] == PARITY) ? line_a : line_b;

        assign bank_o[b].lookup_valid = req_valid_i;
        assign bank_o[b].lookup_index = lnum[INDEX_W+BANK_W-1:BANK_W];
        assign bank_o[b].lookup_tag   = lnum[LINE_NUM_W-1 -: TAG_W];

        assign bank_o[b].fill_valid   = fill_valid_i && (fill_bank == PARITY);
        assign bank_o[b].fill_index   = fill_index;
        assign bank_o[b].fill_tag     = fill_tag;
        assign bank_o[b].fill_line    = fill_line_i;  // same data to both, only one writes
    end

endmodule

`default_nettype wire

// ==== hdl/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    localparam int ADDR_W        = 32;
    localparam int LINE_BYTES    = 16;
    localparam int LINE_W        = LINE_BYTES * 8;
    localparam int OFFSET_W      = $clog2(LINE_BYTES);   // addr[3:0]

    // two banks, split by line number parity
    localparam int NUM_BANKS     = 2;
    localparam int BANK_W        = $clog2(NUM_BANKS);    // addr[4]

    localparam int SETS_PER_BANK = 16;
    localparam int INDEX_W       = $clog2(SETS_PER_BANK); // addr[8:5]

    localparam int LINE_NUM_W    = ADDR_W - OFFSET_W;
    localparam int TAG_W         = ADDR_W - OFFSET_W - BANK_W - INDEX_W; // addr[31:9]

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [LINE_W-1:0]   line_t;   // byte 0 in bits 7:0
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    ctag_t;
    typedef logic [OFFSET_W-1:0] offset_t;

endpackage

`default_nettype wire

// ==== hdl/dcache_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_bank import cache_geom_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    bank_if.bank bus_io
);

    logic [SETS_PER_BANK-1:0] valid_q;
    ctag_t                    tag_mem  [SETS_PER_BANK];
    line_t                    line_mem [SETS_PER_BANK];

    logic                     tag_match;
    logic                     rd_hit_q;
    line_t                    rd_line_q;

    // direct mapped, one way per set
    assign tag_match = valid_q[bus_io.lookup_index] &&
                       (tag_mem[bus_io.lookup_index] == bus_io.lookup_tag);

    // valid bits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (bus_io.fill_valid) begin
            valid_q[bus_io.fill_index] <= 1'b1;
        end
    end

    // tag and data arrays, written at the edge
    always_ff @(posedge clk) begin
        if (bus_io.fill_valid) begin
            tag_mem[bus_io.fill_index]  <= bus_io.fill_tag;
            line_mem[bus_io.fill_index] <= bus_io.fill_line;
        end
    end

    // registered lookup
    // a fill in the same cycle is not seen yet
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_hit_q <= 1'b0;
        end else begin
            rd_hit_q <= bus_io.lookup_valid && tag_match;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_io.lookup_valid) begin
            rd_line_q <= line_mem[bus_io.lookup_index];
        end
    end

    assign bus_io.rd_hit  = rd_hit_q;
    assign bus_io.rd_line = rd_line_q;

endmodule

`default_nettype wire

// ==== hdl/dcache_pair.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_pair import cache_geom_pkg::*, load_req_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,

    // load request, one per cycle at most
    input  logic     req_valid_i,
    input  addr_t    req_addr_i,
    input  size_e    req_size_i,
    input  logic     req_sext_i,
    input  ooo_tag_t req_tag_i,

    // whole-line fill
    input  logic     fill_valid_i,
    input  addr_t    fill_addr_i,
    input  line_t    fill_line_i,

    // result, one clock after the request
    output logic     load_valid_o,
    output logic     load_hit_o,
    output word_t    load_data_o,
    output ooo_tag_t load_tag_o
);

    bank_if bank_bus [NUM_BANKS] ();   // index 0 even, 1 odd

    bank_req_split u_split (
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .fill_valid_i (fill_valid_i),
        .fill_addr_i  (fill_addr_i),
        .fill_line_i  (fill_line_i),
        .bank_o       (bank_bus)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dcache_bank u_bank (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .bus_io  (bank_bus[b])
        );
    end

    // request details go to the merger directly
    line_merge u_merge (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_size_i   (req_size_i),
        .req_sext_i   (req_sext_i),
        .req_tag_i    (req_tag_i),
        .bank_i       (bank_bus),
        .load_valid_o (load_valid_o),
        .load_hit_o   (load_hit_o),
        .load_data_o  (load_data_o),
        .load_tag_o   (load_tag_o)
    );

endmodule

`default_nettype wire

// ==== hdl/line_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_merge import cache_geom_pkg::*, load_req_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  addr_t    req_addr_i,
    input  size_e    req_size_i,
    input  logic     req_sext_i,
    input  ooo_tag_t req_tag_i,
    bank_if.merge    bank_i [NUM_BANKS],
    output logic     load_valid_o,
    output logic     load_hit_o,
    output word_t    load_data_o,
    output ooo_tag_t load_tag_o
);

    logic                valid_q;
    logic                bank_q;      // bank of the addressed line
    offset_t             offset_q;
    size_e               size_q;
    logic                sext_q;
    ooo_tag_t            tag_q;

    logic                rd_hit  [NUM_BANKS];
    line_t               rd_line [NUM_BANKS];
    logic                first_hit;
    logic                second_hit;
    line_t               first_line;
    line_t               second_line;

    logic [OFFSET_W:0]   acc_bytes;
    logic [OFFSET_W:0]   end_byte;
    logic                crossing;
    logic [2*LINE_W-1:0] pair_line;
    logic [2*LINE_W-1:0] pair_shift;
    word_t               raw_word;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_rd
        assign rd_hit[b]  = bank_i[b].rd_hit;
        assign rd_line[b] = bank_i[b].rd_line;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid_i;
        end
    end

    // request details held for the read stage
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            bank_q   <= req_addr_i[OFFSET_W];
            offset_q <= req_addr_i[OFFSET_W-1:0];
            size_q   <= req_size_i;
            sext_q   <= req_sext_i;
            tag_q    <= req_tag_i;
        end
    end

    assign first_hit   = rd_hit[bank_q];
    assign second_hit  = rd_hit[~bank_q];
    assign first_line  = rd_line[bank_q];
    assign second_line = rd_line[~bank_q];

    always_comb begin
        case (size_q)
            SIZE_BYTE: acc_bytes = 5'd1;
            SIZE_HALF: acc_bytes = 5'd2;
            SIZE_WORD: acc_bytes = 5'd4;
            default:   acc_bytes = 5'd0;
        endcase
    end

    assign end_byte = {1'b0, offset_q} + acc_bytes;
    assign crossing = end_byte > LINE_BYTES;  // spills into the next line

    assign load_hit_o = first_hit && (second_hit || !crossing);

    assign pair_line  = {second_line, first_line};
    assign pair_shift = pair_line >> {offset_q, 3'b000};
    assign raw_word   = pair_shift[WORD_W-1:0];

    // size select and extension
    always_comb begin
        case (size_q)
            SIZE_BYTE: load_data_o = {{(WORD_W-8){sext_q & raw_word[7]}}, raw_word[7:0]};
            SIZE_HALF: load_data_o = {{(WORD_W-16){sext_q & raw_word[15]}}, raw_word[15:0]};
            SIZE_WORD: load_data_o = raw_word;
            default:   load_data_o = '0;
        endcase
    end

    assign load_valid_o = valid_q;
    assign load_tag_o   = tag_q;

endmodule

`default_nettype wire

// ==== hdl/load_req_pkg.sv ====
`default_nettype none

package load_req_pkg;

    localparam int OOO_TAG_W = 10;
    localparam int WORD_W    = 32;

    // access size of a load
    // value 3 is never issued, the merger returns zero for it
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef logic [OOO_TAG_W-1:0] ooo_tag_t;  // comes back with the result unchanged
    typedef logic [WORD_W-1:0]    word_t;

endpackage

`default_nettype wire

// ==== src.f ====
hdl/cache_geom_pkg.sv
hdl/load_req_pkg.sv
hdl/bank_if.sv
hdl/bank_req_split.sv
hdl/dcache_bank.sv
hdl/line_merge.sv
hdl/dcache_pair.sv
bench/tb_dcache_pair.sv
